//--- Makefile
# Verilator build and run of the SPI flash controller testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module flash_ctrl_tb -Mdir obj_dir -f sources.f
	./obj_dir/Vflash_ctrl_tb | tee sim.log
	grep -qx "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- common/flash_config.svh
`ifndef FLASH_CONFIG_SVH
`define FLASH_CONFIG_SVH

////////////////////////////////////////////////////////////
// SPI flash controller configuration
////////////////////////////////////////////////////////////

// System clocks per SCK half period
`define FLASH_PRESCALE 20

`define FLASH_ADDR_BITS 24
`define FLASH_WORD_BITS 32
`define FLASH_CMD_BITS 8

`define FLASH_CS_IDLE 1    // SCK periods with cs_n high between commands
`define FLASH_WIP_BIT 0    // Write in progress bit of the status register

`endif

//--- common/flash_pkg.sv
`default_nettype none

`include "flash_config.svh"

package flash_pkg;

    typedef logic [`FLASH_ADDR_BITS-1:0] flash_addr_t;  // Byte address
    typedef logic [`FLASH_WORD_BITS-1:0] flash_word_t;
    typedef logic [`FLASH_CMD_BITS-1:0] flash_cmd_t;
    typedef logic [7:0] flash_status_t;
    typedef logic [5:0] frame_len_t;                     // Bits per frame

    // Single-bit SPI opcodes
    typedef enum flash_cmd_t {
        OP_READ    = 8'h03,
        OP_WREN    = 8'h06,
        OP_PROGRAM = 8'h02,
        OP_RDSR    = 8'h05
    } flash_opcode_t;

    // What the result stage does with a finished frame
    typedef enum logic [1:0] {
        KIND_NONE   = 2'd0,
        KIND_DATA   = 2'd1,
        KIND_STATUS = 2'd2
    } frame_kind_t;

    typedef enum logic [2:0] {
        IDLE, READ_CMD, READ_DATA, WREN, CS_GAP, PROG_CMD, PROG_DATA, POLL
    } seq_state_t;

endpackage

`default_nettype wire

//--- common/spi_frame_if.sv
`default_nettype none

// One serial frame from the sequencer to the engine and on to the result stage
interface spi_frame_if
    import flash_pkg::*;
();
    logic        start;     // One-cycle request
    flash_word_t tx_data;   // MSB first
    frame_len_t  tx_bits;
    frame_len_t  rx_bits;
    frame_kind_t kind;
    logic        done;      // One cycle after last falling SCK
    flash_word_t rx_data;   // Valid with done

    modport seq (
        output start, tx_data, tx_bits, rx_bits, kind,
        input  done
    );

    modport engine (
        input  start, tx_data, tx_bits, rx_bits,
        output done, rx_data
    );

    modport result (
        input done, rx_data, kind
    );

endinterface

`default_nettype wire

//--- flash_ctrl/flash_cmd_sequencer.sv
`default_nettype none

`include "flash_config.svh"

module flash_cmd_sequencer
    import flash_pkg::*;
#(
    parameter int PRESCALE = `FLASH_PRESCALE
) (
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        i_write,
    input  logic        i_dir,       // 0 read, 1 program
    input  logic        i_op_cont,
    input  flash_addr_t i_address,
    input  flash_word_t i_word,
    input  logic        wip,
    output logic        cs_n,
    output logic        busy,
    spi_frame_if.seq    frame
);

    // cs_n high time in system clocks
    localparam int GAP_CLKS = `FLASH_CS_IDLE * 2 * PRESCALE;
    localparam int GAP_BITS = (GAP_CLKS > 1) ? $clog2(GAP_CLKS) : 1;
    localparam logic [GAP_BITS-1:0] GAP_LAST = GAP_BITS'(GAP_CLKS - 1);

    localparam frame_len_t CMD_LEN  = frame_len_t'(`FLASH_CMD_BITS);
    localparam frame_len_t ADDR_LEN = frame_len_t'(`FLASH_CMD_BITS + `FLASH_ADDR_BITS);
    localparam frame_len_t WORD_LEN = frame_len_t'(`FLASH_WORD_BITS);

    seq_state_t          state;
    seq_state_t          gap_next;    // Where CS_GAP goes
    logic                check_wip;   // Gap follows a status poll
    logic                dir_q;
    flash_addr_t         addr_q;
    logic [GAP_BITS-1:0] gap_cnt;

    assign busy = (state != IDLE);

    ////////////////////////////////////////////////////////////
    // Frame contents decoded from the current state
    ////////////////////////////////////////////////////////////
    always_comb begin
        frame.tx_data = '0;
        frame.tx_bits = '0;
        frame.rx_bits = '0;
        frame.kind    = KIND_NONE;
        case (state)
            READ_CMD: begin
                frame.tx_data = {OP_READ, addr_q};
                frame.tx_bits = ADDR_LEN;
            end
            READ_DATA: begin
                frame.rx_bits = WORD_LEN;
                frame.kind    = KIND_DATA;
            end
            WREN: begin
                frame.tx_data = {OP_WREN, {`FLASH_ADDR_BITS{1'b0}}};
                frame.tx_bits = CMD_LEN;
            end
            PROG_CMD: begin
                frame.tx_data = {OP_PROGRAM, addr_q};
                frame.tx_bits = ADDR_LEN;
            end
            PROG_DATA: begin
                frame.tx_data = i_word;     // Taken by the engine at start
                frame.tx_bits = WORD_LEN;
            end
            POLL: begin
                frame.tx_data = {OP_RDSR, {`FLASH_ADDR_BITS{1'b0}}};
                frame.tx_bits = CMD_LEN;
                frame.rx_bits = CMD_LEN;
                frame.kind    = KIND_STATUS;
            end
            default: ;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (state == IDLE && i_write) addr_q <= i_address;
    end

    ////////////////////////////////////////////////////////////
    // Command FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state       <= IDLE;
            gap_next    <= IDLE;
            check_wip   <= 1'b0;
            dir_q       <= 1'b0;
            gap_cnt     <= '0;
            cs_n        <= 1'b1;
            frame.start <= 1'b0;
        end else begin
            frame.start <= 1'b0;
            case (state)
                IDLE: begin
                    if (i_write) begin
                        dir_q       <= i_dir;
                        cs_n        <= 1'b0;
                        frame.start <= 1'b1;
                        state       <= i_dir ? WREN : READ_CMD;
                    end
                end
                READ_CMD, PROG_CMD: begin
                    if (frame.done) begin
                        frame.start <= 1'b1;
                        state       <= dir_q ? PROG_DATA : READ_DATA;
                    end
                end
                READ_DATA, PROG_DATA: begin
                    if (frame.done) begin
                        if (i_op_cont) begin
                            frame.start <= 1'b1;    // Stream next word
                        end else begin
                            cs_n      <= 1'b1;
                            gap_cnt   <= GAP_LAST;
                            gap_next  <= dir_q ? POLL : IDLE;
                            check_wip <= 1'b0;
                            state     <= CS_GAP;
                        end
                    end
                end
                WREN: begin
                    if (frame.done) begin
                        cs_n      <= 1'b1;
                        gap_cnt   <= GAP_LAST;
                        gap_next  <= PROG_CMD;
                        check_wip <= 1'b0;
                        state     <= CS_GAP;
                    end
                end
                POLL: begin
                    if (frame.done) begin
                        cs_n      <= 1'b1;
                        gap_cnt   <= GAP_LAST;
                        gap_next  <= POLL;
                        check_wip <= 1'b1;  // Status lands during the gap
                        state     <= CS_GAP;
                    end
                end
                CS_GAP: begin
                    if (gap_cnt != '0) begin
                        gap_cnt <= gap_cnt - 1'b1;
                    end else if (gap_next == IDLE || (check_wip && !wip)) begin
                        state <= IDLE;
                    end else begin
                        cs_n        <= 1'b0;
                        frame.start <= 1'b1;
                        state       <= gap_next;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- flash_ctrl/read_word_capture.sv
`default_nettype none

`include "flash_config.svh"

module read_word_capture
    import flash_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_reset,
    output flash_word_t o_word,
    output logic        o_valid,
    output logic        wip,
    spi_frame_if.result frame
);

    flash_status_t status_q;   // Last RDSR byte

    logic data_done;
    logic status_done;

    assign data_done   = frame.done && (frame.kind == KIND_DATA);
    assign status_done = frame.done && (frame.kind == KIND_STATUS);
    assign wip         = status_q[`FLASH_WIP_BIT];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_valid  <= 1'b0;
            status_q <= '0;
        end else begin
            o_valid <= data_done;   // Single cycle pulse
            if (status_done) status_q <= frame.rx_data[7:0];
        end
    end

    // Read word held until the next one
    always_ff @(posedge i_clk) begin
        if (data_done) o_word <= frame.rx_data;
    end

endmodule

`default_nettype wire

//--- flash_ctrl/spi_shift_engine.sv
`default_nettype none

`include "flash_config.svh"

module spi_shift_engine
    import flash_pkg::*;
#(
    parameter int PRESCALE = `FLASH_PRESCALE
) (
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        miso,
    output logic        sck,
    output logic        mosi,
    spi_frame_if.engine frame
);

    localparam int WORD_BITS = `FLASH_WORD_BITS;
    localparam int CNT_BITS  = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;
    localparam logic [CNT_BITS-1:0] HALF_LAST = CNT_BITS'(PRESCALE - 1);

    logic [CNT_BITS-1:0] pre_cnt;
    logic                running;
    logic                tick;        // SCK edge due
    frame_len_t          tx_left;     // Bits still to send
    frame_len_t          bits_left;   // Bits left in the frame
    flash_word_t         shift_q;

    assign tick          = running && (pre_cnt == '0);
    assign frame.rx_data = shift_q;

    ////////////////////////////////////////////////////////////
    // Half period prescaler
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_reset || !running || tick) begin
            pre_cnt <= HALF_LAST;
        end else begin
            pre_cnt <= pre_cnt - 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Frame control with SCK and mosi
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            running    <= 1'b0;
            sck        <= 1'b0;
            mosi       <= 1'b0;
            tx_left    <= '0;
            bits_left  <= '0;
            frame.done <= 1'b0;
        end else begin
            frame.done <= 1'b0;
            if (!running) begin
                if (frame.start) begin
                    running   <= 1'b1;
                    tx_left   <= frame.tx_bits;
                    bits_left <= frame.tx_bits + frame.rx_bits;
                    // First bit goes out with start
                    mosi      <= (frame.tx_bits != '0) && frame.tx_data[WORD_BITS-1];
                end
            end else if (tick) begin
                sck <= !sck;
                if (sck) begin
                    // Falling edge closes a bit
                    bits_left <= bits_left - 1'b1;
                    if (tx_left != '0) tx_left <= tx_left - 1'b1;
                    mosi <= (tx_left > 6'd1) && shift_q[WORD_BITS-2];
                    if (bits_left == 6'd1) begin
                        running    <= 1'b0;
                        frame.done <= 1'b1;
                    end
                end
            end
        end
    end

    // Shared shift register that shifts out on falling and in on rising SCK
    always_ff @(posedge i_clk) begin
        if (!running && frame.start) begin
            shift_q <= frame.tx_data;
        end else if (tick) begin
            if (!sck && tx_left == '0) begin
                shift_q <= {shift_q[WORD_BITS-2:0], miso};
            end else if (sck && tx_left > 6'd1) begin
                shift_q <= {shift_q[WORD_BITS-2:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+common
common/flash_pkg.sv
common/spi_frame_if.sv
flash_ctrl/flash_cmd_sequencer.sv
flash_ctrl/spi_shift_engine.sv
flash_ctrl/read_word_capture.sv
verilog/flash_ctrl_top.sv
verification/spi_flash_model.sv
verification/flash_ctrl_checker.sv
verification/flash_ctrl_tb.sv

//--- verification/flash_ctrl_checker.sv
`default_nettype none

module flash_ctrl_checker
    import flash_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_reset,
    input  flash_word_t word,
    input  logic        valid,
    input  logic        busy,
    input  logic        cs_n,
    input  logic        sck,
    input  logic        push,
    input  flash_word_t push_word,
    output int          error_count,
    output int          pending
);

    flash_word_t expected_q [$];
    flash_word_t exp_word;
    int          errs = 0;

    always @(posedge i_clk) begin
        if (push) expected_q.push_back(push_word);
        if (!i_reset) begin
            if (valid && expected_q.size() == 0) begin
                $display("o_valid pulsed with no expected word, o_word was %h", word);
                errs++;
            end else if (valid) begin
                exp_word = expected_q.pop_front();
                if (word !== exp_word) begin
                    $display("CHECK FAILED o_word got %h expected %h", word, exp_word);
                    errs++;
                end
            end
            // Idle pin levels
            if (!busy && cs_n !== 1'b1) begin
                $display("CHECK FAILED flash_cs_n got %h expected %h", cs_n, 1'b1);
                errs++;
            end
            if (!busy && sck !== 1'b0) begin
                $display("CHECK FAILED flash_sck got %h expected %h", sck, 1'b0);
                errs++;
            end
            if (!busy && valid !== 1'b0) begin
                $display("CHECK FAILED o_valid got %h expected %h", valid, 1'b0);
                errs++;
            end
        end
        error_count <= errs;
        pending     <= expected_q.size();
    end

endmodule

`default_nettype wire

//--- verification/flash_ctrl_tb.sv
`default_nettype none

module flash_ctrl_tb
    import flash_pkg::*;
();

    localparam int          PRESCALE = 2;
    localparam int          TIMEOUT  = 20000;
    localparam logic [31:0] SEED     = 32'h62dd30e1;

    logic        i_clk;
    logic        i_reset;
    logic        i_write;
    logic        i_dir;
    logic        i_op_cont;
    flash_addr_t i_address;
    flash_word_t i_word;
    flash_word_t o_word;
    logic        o_valid;
    logic        o_busy;
    logic        flash_cs_n;
    logic        flash_sck;
    logic        flash_mosi;
    logic        flash_miso;

    logic        exp_push;
    flash_word_t exp_word;
    int          chk_errors;
    int          pending;
    int          model_cmds;
    int          model_polls;
    int          model_busy;
    int          model_errors;
    int          tb_errors;

    logic [7:0]  ref_mem [flash_addr_t];    // Expected flash contents
    flash_word_t wbuf [64];                 // Words for the next program

    flash_ctrl_top #(.PRESCALE(PRESCALE)) flash_ctrl_top_i (.*);

    spi_flash_model spi_flash_model_i (
        .sck         (flash_sck),
        .cs_n        (flash_cs_n),
        .mosi        (flash_mosi),
        .miso        (flash_miso),
        .cmd_count   (model_cmds),
        .poll_count  (model_polls),
        .busy_polls  (model_busy),
        .error_count (model_errors)
    );

    flash_ctrl_checker flash_ctrl_checker_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .word        (o_word),
        .valid       (o_valid),
        .busy        (o_busy),
        .cs_n        (flash_cs_n),
        .sck         (flash_sck),
        .push        (exp_push),
        .push_word   (exp_word),
        .error_count (chk_errors),
        .pending     (pending)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = !i_clk;
    end

    function automatic logic [7:0] ref_byte(input flash_addr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : 8'hFF;
    endfunction

    function automatic flash_word_t ref_word(input flash_addr_t a);
        return {ref_byte(a), ref_byte(a + 24'd1), ref_byte(a + 24'd2), ref_byte(a + 24'd3)};
    endfunction

    // Word aligned so that n words fit in the page
    function automatic flash_addr_t rand_addr(input int n);
        flash_addr_t a;
        a[23:8] = 16'($urandom);
        a[7:0]  = 8'($urandom_range(64 - n, 0) * 4);
        return a;
    endfunction

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            tb_errors++;
        end
    endtask

    task automatic finish_run();
        $display("Errors: checker %0d, flash model %0d, testbench %0d",
                 chk_errors, model_errors, tb_errors);
        if (chk_errors + model_errors + tb_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        tb_errors++;
        finish_run();
    endtask

    ////////////////////////////////////////////////////////////
    // One read or program of n words with an optional i_write poke
    ////////////////////////////////////////////////////////////
    task automatic run_op(input logic dir, input flash_addr_t addr, input int n,
                          input int poke);
        int          cycles;
        int          seen;
        int          rises;
        int          cs_falls;
        int          k;
        int          b;
        int          cmds;
        int          polls;
        logic        sck_q;
        logic        cs_q;
        flash_addr_t a;
        cmds  = model_cmds;
        polls = model_polls;
        for (k = 0; k < n && !dir; k++) begin
            @(posedge i_clk);
            exp_push <= 1'b1;
            exp_word <= ref_word(flash_addr_t'(addr + 4 * k));
        end
        @(posedge i_clk);
        exp_push  <= 1'b0;
        i_write   <= 1'b1;
        i_dir     <= dir;
        i_address <= addr;
        i_word    <= wbuf[0];
        i_op_cont <= (n > 1);
        @(posedge i_clk);
        i_write  <= 1'b0;
        cycles   = 0;
        seen     = 0;
        rises    = 0;
        cs_falls = 0;
        sck_q    = 1'b0;
        cs_q     = 1'b1;
        do begin
            @(posedge i_clk);
            cycles++;
            if (cycles == poke) begin
                i_write   <= 1'b1;
                i_dir     <= 1'b1;
                i_address <= addr ^ 24'h000800;
            end
            if (cycles == poke + 1) i_write <= 1'b0;
            if (o_valid) begin
                seen++;
                if (seen == n - 1) i_op_cont <= 1'b0;   // Last word in flight
            end
            if (cs_q && !flash_cs_n) cs_falls++;
            // Word k-1 has left the DUT so present word k next
            if (dir && cs_falls == 2 && flash_sck && !sck_q) begin
                rises++;
                if (rises > 32 && rises % 32 == 1) begin
                    k = rises / 32;
                    if (k < n) i_word <= wbuf[k];
                    else i_op_cont <= 1'b0;
                end
            end
            sck_q = flash_sck;
            cs_q  = flash_cs_n;
        end while (o_busy && cycles < TIMEOUT);
        if (cycles >= TIMEOUT) begin
            abort_run("Timeout while waiting for o_busy to fall");
        end else if (dir) begin
            for (k = 0; k < n; k++) begin
                for (b = 0; b < 4; b++) begin
                    a = flash_addr_t'(addr + 4 * k + b);
                    ref_mem[a] = ref_byte(a) & wbuf[k][31 - 8 * b -: 8];
                end
            end
            check_count("RDSR poll count", model_polls - polls, model_busy + 1);
            check_count("flash command count", model_cmds - cmds, model_polls - polls + 2);
        end else begin
            check_count("o_valid count", seen, n);
            check_count("flash command count", model_cmds - cmds, 1);
        end
    endtask

    initial begin
        flash_addr_t a;
        int          n;
        int          m;
        int          k;
        void'($urandom(SEED));
        tb_errors = 0;
        i_reset   = 1'b1;
        i_write   = 1'b0;
        i_dir     = 1'b0;
        i_op_cont = 1'b0;
        i_address = '0;
        i_word    = '0;
        exp_push  = 1'b0;
        exp_word  = '0;
        repeat (4) @(posedge i_clk);
        i_reset <= 1'b0;

        run_op(1'b0, rand_addr(1), 1, 0);   // Erased word
        wbuf[0] = $urandom;
        a = rand_addr(1);
        run_op(1'b1, a, 1, 0);
        run_op(1'b0, a, 1, 0);

        // Continued programs and a partial overwrite, then a continued read back
        repeat (6) begin
            n = $urandom_range(6, 2);
            m = $urandom_range(n, 1);
            a = rand_addr(n);
            for (k = 0; k < n; k++) wbuf[k] = $urandom;
            run_op(1'b1, a, n, 0);
            for (k = 0; k < m; k++) wbuf[k] = $urandom;
            run_op(1'b1, flash_addr_t'(a + 4 * (n - m)), m, 0);
            run_op(1'b0, a, n, 0);
        end

        // i_write while busy
        a = rand_addr(2);
        run_op(1'b0, a, 2, 40);
        wbuf[0] = $urandom;
        wbuf[1] = $urandom;
        run_op(1'b1, a, 2, 40);
        run_op(1'b0, a ^ 24'h000800, 2, 0);
        run_op(1'b0, a, 2, 0);

        repeat (10) @(posedge i_clk);
        check_count("expected words left", pending, 0);
        finish_run();
    end

endmodule

`default_nettype wire

//--- verification/spi_flash_model.sv
`default_nettype none

`include "flash_config.svh"

// Single-bit SPI NOR flash in mode 0 with bytes stored big-endian
module spi_flash_model
    import flash_pkg::*;
(
    input  logic sck,
    input  logic cs_n,
    input  logic mosi,
    output logic miso,
    output int   cmd_count,
    output int   poll_count,
    output int   busy_polls,    // Busy polls set by the last program
    output int   error_count
);

    logic [7:0]  mem [flash_addr_t];    // Erased bytes are absent
    flash_cmd_t  opcode;
    flash_cmd_t  in_byte;
    flash_addr_t addr;
    logic [7:0]  out_byte;
    logic        wel;                   // Write enable latch
    int          bit_cnt;
    int          busy_left;
    int          k;

    function automatic logic [7:0] mem_byte(input flash_addr_t a);
        return mem.exists(a) ? mem[a] : 8'hFF;
    endfunction

    initial begin
        miso        = 1'b0;
        opcode      = '0;
        wel         = 1'b0;
        bit_cnt     = 0;
        busy_left   = 0;
        cmd_count   = 0;
        poll_count  = 0;
        busy_polls  = 0;
        error_count = 0;
    end

    ////////////////////////////////////////////////////////////
    // Command input with mosi taken on rising SCK
    ////////////////////////////////////////////////////////////
    always @(posedge sck or posedge cs_n) begin
        if (cs_n) begin
            if (opcode == OP_PROGRAM && wel && bit_cnt >= 40) begin
                wel        = 1'b0;
                busy_polls = $urandom_range(3, 0);
                busy_left  = busy_polls;
            end else if (opcode == OP_RDSR && busy_left > 0) begin
                busy_left--;
            end
            bit_cnt = 0;
            opcode  = '0;
        end else begin
            in_byte = {in_byte[6:0], mosi};
            bit_cnt++;
            if (bit_cnt == 8) begin
                opcode = in_byte;
                cmd_count++;
                case (opcode)
                    OP_WREN: wel = 1'b1;
                    OP_RDSR: poll_count++;
                    OP_READ: ;
                    OP_PROGRAM: begin
                        if (!wel) begin
                            $display("Flash model saw a page program without write enable");
                            error_count++;
                        end
                    end
                    default: begin
                        $display("Flash model saw an unknown opcode %h", opcode);
                        error_count++;
                    end
                endcase
            end else if (bit_cnt <= 32) begin
                addr = {addr[22:0], mosi};
            end else if (opcode == OP_PROGRAM && wel && bit_cnt % 8 == 0) begin
                k = (bit_cnt - 40) / 8;
                mem[addr + flash_addr_t'(k)] = mem_byte(addr + flash_addr_t'(k)) & in_byte;
            end
        end
    end

    // Output bits change on falling SCK
    always @(negedge sck) begin
        if (!cs_n && opcode == OP_READ && bit_cnt >= 32) begin
            out_byte = mem_byte(addr + flash_addr_t'((bit_cnt - 32) / 8));
            miso     = out_byte[7 - (bit_cnt - 32) % 8];
        end else if (!cs_n && opcode == OP_RDSR) begin
            out_byte = '0;
            out_byte[`FLASH_WIP_BIT] = (busy_left > 0);
            miso     = out_byte[7 - bit_cnt % 8];
        end
    end

endmodule

`default_nettype wire

//--- verilog/flash_ctrl_top.sv
`default_nettype none

`include "flash_config.svh"

module flash_ctrl_top
    import flash_pkg::*;
#(
    parameter int PRESCALE = `FLASH_PRESCALE
) (
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        i_write,
    input  logic        i_dir,
    input  logic        i_op_cont,
    input  flash_addr_t i_address,
    input  flash_word_t i_word,
    output flash_word_t o_word,
    output logic        o_valid,
    output logic        o_busy,
    // SPI flash pins
    output logic        flash_cs_n,
    output logic        flash_sck,
    output logic        flash_mosi,
    input  logic        flash_miso
);

    spi_frame_if frame_if ();

    logic wip;

    flash_cmd_sequencer #(.PRESCALE(PRESCALE)) flash_cmd_sequencer_i (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_write   (i_write),
        .i_dir     (i_dir),
        .i_op_cont (i_op_cont),
        .i_address (i_address),
        .i_word    (i_word),
        .wip       (wip),
        .cs_n      (flash_cs_n),
        .busy      (o_busy),
        .frame     (frame_if.seq)
    );

    spi_shift_engine #(.PRESCALE(PRESCALE)) spi_shift_engine_i (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .miso    (flash_miso),
        .sck     (flash_sck),
        .mosi    (flash_mosi),
        .frame   (frame_if.engine)
    );

    read_word_capture read_word_capture_i (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .o_word  (o_word),
        .o_valid (o_valid),
        .wip     (wip),
        .frame   (frame_if.result)
    );

endmodule

`default_nettype wire
